// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= core_bus_tb
RTL_TOP   ?= core_bus_top
FILELIST  ?= files.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

RTL_FILES := $(filter rtl/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(RTL_FILES) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== files.f ====
rtl/bus_types_pkg.sv
rtl/soc_map_pkg.sv
rtl/lane_align.sv
rtl/clint_timer.sv
rtl/bus_arbiter.sv
rtl/core_bus_top.sv
verif/axi_mem_model.sv
verif/core_bus_tb.sv

// ==== rtl/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter
  import bus_types_pkg::*;
  import soc_map_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  // ifu fetch
  input  logic       ifu_arvalid_i,
  input  addr_t      ifu_araddr_i,
  output logic       ifu_rvalid_o,
  output word_t      ifu_rdata_o,
  // lsu load
  input  logic       lsu_arvalid_i,
  input  addr_t      lsu_araddr_i,
  input  core_strb_t lsu_rstrb_i,
  output logic       lsu_rvalid_o,
  output word_t      lsu_rdata_o,
  // lsu store
  input  logic       lsu_wvalid_i,
  input  addr_t      lsu_awaddr_i,
  input  word_t      lsu_wdata_i,
  input  core_strb_t lsu_wstrb_i,
  output logic       lsu_wready_o,
  // AR and R
  output addr_t      m_araddr_o,
  output axi_size_t  m_arsize_o,
  output logic       m_arvalid_o,
  input  logic       m_arready_i,
  input  logic       m_rvalid_i,
  input  word_t      aligned_rdata_i,
  output addr_t      rd_offset_o,
  // AW, W and B
  output addr_t      m_awaddr_o,
  output axi_size_t  m_awsize_o,
  output logic       m_awvalid_o,
  input  logic       m_awready_i,
  output logic       m_wvalid_o,
  output word_t      w_word_o,
  output core_strb_t w_mask_o,
  output addr_t      w_addr_o,
  input  logic       m_wready_i,
  input  logic       m_bvalid_i,
  // clint timer
  output logic       clint_rvalid_req_o,
  output logic       clint_rsel_hi_o,
  input  logic       clint_rvalid_i,
  input  word_t      clint_rdata_i
);

  rd_state_e rd_state;
  wr_state_e wr_state;
  logic      rd_grant_lsu;
  logic      clint_pend;
  logic      lsu_take;
  logic      lsu_is_clint;
  logic      aw_fire;
  logic      w_fire;
  logic      aw_done;
  logic      w_done;
  addr_t     rd_addr;
  axi_size_t rd_size;
  axi_size_t wr_size;

  // mask to AXI size, odd masks go out as a word
  function automatic axi_size_t size_of(input core_strb_t mask);
    case (mask)
      8'h01: size_of = SIZE_BYTE;
      8'h03: size_of = SIZE_HALF;
      default: size_of = SIZE_WORD;
    endcase
  endfunction

  // lsu is not counted while its clint read is in flight
  assign lsu_take     = lsu_arvalid_i && !clint_pend;
  assign lsu_is_clint = (lsu_araddr_i == CLINT_MTIME_LO) || (lsu_araddr_i == CLINT_MTIME_HI);

  // clint strobe, never reaches AR
  assign clint_rvalid_req_o = (rd_state == RD_IDLE) && lsu_take && lsu_is_clint;
  assign clint_rsel_hi_o    = (lsu_araddr_i == CLINT_MTIME_HI);

  always_ff @(posedge clk)
  begin
    if (rst)
      clint_pend <= 1'b0;
    else if (clint_rvalid_req_o)
      clint_pend <= 1'b1;
    else if (clint_rvalid_i)
      clint_pend <= 1'b0;
  end

  // read FSM, lsu ahead of ifu
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_state     <= RD_IDLE;
      rd_grant_lsu <= 1'b0;
    end
    else
    begin
      case (rd_state)
        RD_IDLE:
        begin
          if (lsu_take && !lsu_is_clint)
          begin
            rd_state     <= RD_ADDR;
            rd_grant_lsu <= 1'b1;
          end
          else if (ifu_arvalid_i && !lsu_take)
          begin
            rd_state     <= RD_ADDR;
            rd_grant_lsu <= 1'b0;
          end
        end
        RD_ADDR:
          if (m_arready_i)
            rd_state <= RD_WAIT;
        RD_WAIT:
          if (m_rvalid_i)
            rd_state <= RD_IDLE;
        default:
          rd_state <= RD_IDLE;
      endcase
    end
  end

  // read address and size, sampled while idle
  always_ff @(posedge clk)
  begin
    if (rd_state == RD_IDLE)
    begin
      rd_addr <= lsu_take ? lsu_araddr_i : ifu_araddr_i;
      rd_size <= lsu_take ? size_of(lsu_rstrb_i) : SIZE_WORD;
    end
  end

  assign m_arvalid_o = (rd_state == RD_ADDR);
  assign m_araddr_o  = rd_addr;
  assign m_arsize_o  = rd_size;
  assign rd_offset_o = rd_addr;

  // response goes to the granted side only
  assign ifu_rvalid_o = (rd_state == RD_WAIT) && m_rvalid_i && !rd_grant_lsu;
  assign ifu_rdata_o  = aligned_rdata_i;
  assign lsu_rvalid_o = ((rd_state == RD_WAIT) && m_rvalid_i && rd_grant_lsu) || clint_rvalid_i;
  assign lsu_rdata_o  = clint_rvalid_i ? clint_rdata_i : aligned_rdata_i;

  // AW and W fire on their own
  assign aw_fire = m_awvalid_o && m_awready_i;
  assign w_fire  = m_wvalid_o && m_wready_i;
  assign aw_done = !m_awvalid_o || aw_fire;
  assign w_done  = !m_wvalid_o || w_fire;

  // write FSM, valids live only in WR_SEND
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_state    <= WR_IDLE;
      m_awvalid_o <= 1'b0;
      m_wvalid_o  <= 1'b0;
    end
    else
    begin
      case (wr_state)
        WR_IDLE:
        begin
          if (lsu_wvalid_i)
          begin
            wr_state    <= WR_SEND;
            m_awvalid_o <= 1'b1;
            m_wvalid_o  <= 1'b1;
          end
        end
        WR_SEND:
        begin
          if (aw_fire)
            m_awvalid_o <= 1'b0;
          if (w_fire)
            m_wvalid_o <= 1'b0;
          // both sides gone, now wait for B
          if (aw_done && w_done)
            wr_state <= WR_RESP;
        end
        WR_RESP:
          if (m_bvalid_i)
            wr_state <= WR_IDLE;
        default:
          wr_state <= WR_IDLE;
      endcase
    end
  end

  // store fields held steady for AW and W
  always_ff @(posedge clk)
  begin
    if ((wr_state == WR_IDLE) && lsu_wvalid_i)
    begin
      w_addr_o <= lsu_awaddr_i;
      w_word_o <= lsu_wdata_i;
      w_mask_o <= lsu_wstrb_i;
      wr_size  <= size_of(lsu_wstrb_i);
    end
  end

  assign m_awaddr_o   = w_addr_o;
  assign m_awsize_o   = wr_size;
  assign lsu_wready_o = (wr_state == WR_RESP) && m_bvalid_i;

endmodule

// ==== rtl/bus_types_pkg.sv ====
package bus_types_pkg;

  // byte address as seen by the core and the bus
  typedef logic [31:0] addr_t;
  // core data word
  typedef logic [31:0] word_t;
  // one AXI data beat
  typedef logic [63:0] bus_data_t;
  // AXI write strobe, one bit per byte of the beat
  typedef logic [7:0]  bus_strb_t;
  // core byte mask, only bits 3:0 carry meaning
  typedef logic [7:0]  core_strb_t;
  // AXI arsize/awsize code
  typedef logic [2:0]  axi_size_t;

  // size codes, bytes per beat = 2**size
  localparam axi_size_t SIZE_BYTE = 3'd0;
  localparam axi_size_t SIZE_HALF = 3'd1;
  localparam axi_size_t SIZE_WORD = 3'd2;

  // read channel FSM
  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_WAIT} rd_state_e;

  // write channel FSM
  typedef enum logic [1:0] {WR_IDLE, WR_SEND, WR_RESP} wr_state_e;

endpackage

// ==== rtl/clint_timer.sv ====
`timescale 1ns/1ps

module clint_timer
  import bus_types_pkg::*;
  import soc_map_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  // read strobe from the arbiter
  input  logic  rd_req_i,
  // high word select
  input  logic  rd_hi_i,
  // response, one cycle after the strobe
  output logic  rvalid_o,
  output word_t rdata_o
);

  mtime_t mtime;

  // free-running timer, starts at 0 when rst drops
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime <= '0;
    end
    else
    begin
      mtime <= mtime + 64'd1;
    end
  end

  // response pulse follows the strobe by one cycle
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rvalid_o <= 1'b0;
    end
    else
    begin
      rvalid_o <= rd_req_i;
    end
  end

  // half of mtime as seen in the strobe cycle
  always_ff @(posedge clk)
  begin
    if (rd_req_i)
    begin
      rdata_o <= rd_hi_i ? mtime[63:32] : mtime[31:0];
    end
  end

endmodule

// ==== rtl/core_bus_top.sv ====
`timescale 1ns/1ps

module core_bus_top
  import bus_types_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  // ifu fetch
  input  logic       ifu_arvalid_i,
  input  addr_t      ifu_araddr_i,
  output logic       ifu_rvalid_o,
  output word_t      ifu_rdata_o,
  // lsu load
  input  logic       lsu_arvalid_i,
  input  addr_t      lsu_araddr_i,
  input  core_strb_t lsu_rstrb_i,
  output logic       lsu_rvalid_o,
  output word_t      lsu_rdata_o,
  // lsu store
  input  logic       lsu_wvalid_i,
  input  addr_t      lsu_awaddr_i,
  input  word_t      lsu_wdata_i,
  input  core_strb_t lsu_wstrb_i,
  output logic       lsu_wready_o,
  // AXI master, read
  output addr_t      m_araddr_o,
  output axi_size_t  m_arsize_o,
  output logic       m_arvalid_o,
  input  logic       m_arready_i,
  input  logic       m_rvalid_i,
  input  bus_data_t  m_rdata_i,
  // AXI master, write
  output addr_t      m_awaddr_o,
  output axi_size_t  m_awsize_o,
  output logic       m_awvalid_o,
  output logic       m_wvalid_o,
  output bus_data_t  m_wdata_o,
  output bus_strb_t  m_wstrb_o,
  input  logic       m_awready_i,
  input  logic       m_wready_i,
  input  logic       m_bvalid_i
);

  // arbiter to aligner
  addr_t      rd_offset;
  word_t      aligned_rdata;
  addr_t      w_addr;
  word_t      w_word;
  core_strb_t w_mask;
  // arbiter to timer
  logic       clint_req;
  logic       clint_hi;
  logic       clint_rvalid;
  word_t      clint_rdata;

  bus_arbiter u_arb (
    .clk                (clk),
    .rst                (rst),
    .ifu_arvalid_i      (ifu_arvalid_i),
    .ifu_araddr_i       (ifu_araddr_i),
    .ifu_rvalid_o       (ifu_rvalid_o),
    .ifu_rdata_o        (ifu_rdata_o),
    .lsu_arvalid_i      (lsu_arvalid_i),
    .lsu_araddr_i       (lsu_araddr_i),
    .lsu_rstrb_i        (lsu_rstrb_i),
    .lsu_rvalid_o       (lsu_rvalid_o),
    .lsu_rdata_o        (lsu_rdata_o),
    .lsu_wvalid_i       (lsu_wvalid_i),
    .lsu_awaddr_i       (lsu_awaddr_i),
    .lsu_wdata_i        (lsu_wdata_i),
    .lsu_wstrb_i        (lsu_wstrb_i),
    .lsu_wready_o       (lsu_wready_o),
    .m_araddr_o         (m_araddr_o),
    .m_arsize_o         (m_arsize_o),
    .m_arvalid_o        (m_arvalid_o),
    .m_arready_i        (m_arready_i),
    .m_rvalid_i         (m_rvalid_i),
    .aligned_rdata_i    (aligned_rdata),
    .rd_offset_o        (rd_offset),
    .m_awaddr_o         (m_awaddr_o),
    .m_awsize_o         (m_awsize_o),
    .m_awvalid_o        (m_awvalid_o),
    .m_awready_i        (m_awready_i),
    .m_wvalid_o         (m_wvalid_o),
    .w_word_o           (w_word),
    .w_mask_o           (w_mask),
    .w_addr_o           (w_addr),
    .m_wready_i         (m_wready_i),
    .m_bvalid_i         (m_bvalid_i),
    .clint_rvalid_req_o (clint_req),
    .clint_rsel_hi_o    (clint_hi),
    .clint_rvalid_i     (clint_rvalid),
    .clint_rdata_i      (clint_rdata)
  );

  // byte lanes both ways
  lane_align u_align (
    .rd_addr_i (rd_offset),
    .m_rdata_i (m_rdata_i),
    .rdata_o   (aligned_rdata),
    .wr_addr_i (w_addr),
    .wr_word_i (w_word),
    .wr_mask_i (w_mask),
    .m_wdata_o (m_wdata_o),
    .m_wstrb_o (m_wstrb_o)
  );

  clint_timer u_clint (
    .clk      (clk),
    .rst      (rst),
    .rd_req_i (clint_req),
    .rd_hi_i  (clint_hi),
    .rvalid_o (clint_rvalid),
    .rdata_o  (clint_rdata)
  );

endmodule

// ==== rtl/lane_align.sv ====
`timescale 1ns/1ps

module lane_align
  import bus_types_pkg::*;
(
  // read side
  input  addr_t      rd_addr_i,
  input  bus_data_t  m_rdata_i,
  output word_t      rdata_o,
  // write side
  input  addr_t      wr_addr_i,
  input  word_t      wr_word_i,
  input  core_strb_t wr_mask_i,
  output bus_data_t  m_wdata_o,
  output bus_strb_t  m_wstrb_o
);

  word_t      rd_half;
  word_t      wr_lane;
  logic [3:0] mask_lane;

  // bit 2 picks the 32-bit half of the beat
  assign rd_half = rd_addr_i[2] ? m_rdata_i[63:32] : m_rdata_i[31:0];

  // move addressed byte down to bit 0
  // zero fill, sign extension is left to the lsu
  always_comb
  begin
    case (rd_addr_i[1:0])
      2'd0: rdata_o = rd_half;
      2'd1: rdata_o = {8'h00, rd_half[31:8]};
      2'd2: rdata_o = {16'h0000, rd_half[31:16]};
      default: rdata_o = {24'h000000, rd_half[31:24]};
    endcase
  end

  // store word moved up to its byte offset
  always_comb
  begin
    case (wr_addr_i[1:0])
      2'd0: wr_lane = wr_word_i;
      2'd1: wr_lane = {wr_word_i[23:0], 8'h00};
      2'd2: wr_lane = {wr_word_i[15:0], 16'h0000};
      default: wr_lane = {wr_word_i[7:0], 24'h000000};
    endcase
  end

  // same word in both halves, the strobe decides which one lands
  assign m_wdata_o = {wr_lane, wr_lane};

  // 4-bit mask shifted by the byte offset
  // bits pushed past bit 3 fall off
  always_comb
  begin
    case (wr_addr_i[1:0])
      2'd0: mask_lane = wr_mask_i[3:0];
      2'd1: mask_lane = {wr_mask_i[2:0], 1'b0};
      2'd2: mask_lane = {wr_mask_i[1:0], 2'b00};
      default: mask_lane = {wr_mask_i[0], 3'b000};
    endcase
  end

  // upper or lower strobe nibble
  assign m_wstrb_o = wr_addr_i[2] ? {mask_lane, 4'h0} : {4'h0, mask_lane};

endmodule

// ==== rtl/soc_map_pkg.sv ====
package soc_map_pkg;

  // machine timer, full width
  typedef logic [63:0] mtime_t;

  // clint timer words, read-only from the core
  // low half of mtime
  localparam logic [31:0] CLINT_MTIME_LO = 32'h0200_bff8;
  // high half of mtime
  localparam logic [31:0] CLINT_MTIME_HI = 32'h0200_bffc;

endpackage

// ==== verif/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model
  import bus_types_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  // AR and R
  input  addr_t     araddr_i,
  input  logic      arvalid_i,
  output logic      arready_o,
  output logic      rvalid_o,
  output bus_data_t rdata_o,
  // AW, W and B
  input  addr_t     awaddr_i,
  input  logic      awvalid_i,
  output logic      awready_o,
  input  bus_data_t wdata_i,
  input  bus_strb_t wstrb_i,
  input  logic      wvalid_i,
  output logic      wready_o,
  output logic      bvalid_o
);

  // 4 KiB of bytes, upper address bits ignored
  logic [7:0] mem [0:4095];
  logic       rd_busy;
  logic [2:0] rd_cnt;
  addr_t      rd_addr;
  logic       aw_got;
  logic       w_got;
  addr_t      wr_addr;
  bus_data_t  wr_data;
  bus_strb_t  wr_strb;
  logic       b_busy;
  logic [2:0] b_cnt;

  // every bit of the byte address shows up in the pattern
  function automatic logic [7:0] fill_byte(input logic [11:0] a);
    return a[7:0] ^ {a[3:0], a[11:8]} ^ 8'h5a;
  endfunction

  function automatic bus_data_t read_beat(input addr_t a);
    bus_data_t beat;
    for (int i = 0; i < 8; i++)
      beat[8*i +: 8] = mem[{a[11:3], 3'b000} + i];
    return beat;
  endfunction

  initial
  begin
    for (int i = 0; i < 4096; i++)
      mem[i] = fill_byte(i[11:0]);
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    awready_o = 1'b0;
    wready_o  = 1'b0;
    bvalid_o  = 1'b0;
  end

  always @(posedge clk)
  begin : step
    logic      aw_now;
    logic      w_now;
    addr_t     a_use;
    bus_data_t d_use;
    bus_strb_t s_use;
    aw_now = aw_got || (awvalid_i && awready_o);
    w_now  = w_got || (wvalid_i && wready_o);
    a_use  = aw_got ? wr_addr : awaddr_i;
    d_use  = w_got ? wr_data : wdata_i;
    s_use  = w_got ? wr_strb : wstrb_i;
    if (rst)
    begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      rd_busy   <= 1'b0;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      b_busy    <= 1'b0;
    end
    else
    begin
      rvalid_o <= 1'b0;
      bvalid_o <= 1'b0;
      // one read at a time, 1 to 4 cycles of latency
      if (arvalid_i && arready_o)
      begin
        rd_busy   <= 1'b1;
        rd_addr   <= araddr_i;
        rd_cnt    <= 3'(1 + ($urandom % 4));
        arready_o <= 1'b0;
      end
      else if (rd_busy)
      begin
        arready_o <= 1'b0;
        if (rd_cnt == 3'd1)
        begin
          rvalid_o <= 1'b1;
          rdata_o  <= read_beat(rd_addr);
          rd_busy  <= 1'b0;
        end
        else
          rd_cnt <= rd_cnt - 3'd1;
      end
      else
        arready_o <= ($urandom % 3) != 0;
      // write lands once AW and W have both fired
      if (b_busy)
      begin
        awready_o <= 1'b0;
        wready_o  <= 1'b0;
        if (b_cnt == 3'd1)
        begin
          bvalid_o <= 1'b1;
          b_busy   <= 1'b0;
        end
        else
          b_cnt <= b_cnt - 3'd1;
      end
      else if (aw_now && w_now)
      begin
        for (int i = 0; i < 8; i++)
          if (s_use[i])
            mem[{a_use[11:3], 3'b000} + i] = d_use[8*i +: 8];
        b_busy    <= 1'b1;
        b_cnt     <= 3'(1 + ($urandom % 4));
        aw_got    <= 1'b0;
        w_got     <= 1'b0;
        awready_o <= 1'b0;
        wready_o  <= 1'b0;
      end
      else
      begin
        if (aw_now)
        begin
          aw_got    <= 1'b1;
          wr_addr   <= a_use;
          awready_o <= 1'b0;
        end
        else
          awready_o <= ($urandom % 3) != 0;
        if (w_now)
        begin
          w_got    <= 1'b1;
          wr_data  <= d_use;
          wr_strb  <= s_use;
          wready_o <= 1'b0;
        end
        else
          wready_o <= ($urandom % 3) != 0;
      end
    end
  end

endmodule

// ==== verif/core_bus_tb.sv ====
`timescale 1ns/1ps

module core_bus_tb
  import bus_types_pkg::*;
  import soc_map_pkg::*;
();

  // clint pair, fetches, loads, odd mask, ifu/lsu pair, stores with readback, overlap
  localparam int N_OPS = 2 + 4 + 24 + 1 + 2 + 48 + 3;
  localparam int RST_CYCLES = 16;

  logic       clk;
  logic       rst;
  logic       ifu_arvalid_i;
  addr_t      ifu_araddr_i;
  logic       ifu_rvalid_o;
  word_t      ifu_rdata_o;
  logic       lsu_arvalid_i;
  addr_t      lsu_araddr_i;
  core_strb_t lsu_rstrb_i;
  logic       lsu_rvalid_o;
  word_t      lsu_rdata_o;
  logic       lsu_wvalid_i;
  addr_t      lsu_awaddr_i;
  word_t      lsu_wdata_i;
  core_strb_t lsu_wstrb_i;
  logic       lsu_wready_o;
  addr_t      m_araddr_o;
  axi_size_t  m_arsize_o;
  logic       m_arvalid_o;
  logic       m_arready_i;
  logic       m_rvalid_i;
  bus_data_t  m_rdata_i;
  addr_t      m_awaddr_o;
  axi_size_t  m_awsize_o;
  logic       m_awvalid_o;
  logic       m_wvalid_o;
  bus_data_t  m_wdata_o;
  bus_strb_t  m_wstrb_o;
  logic       m_awready_i;
  logic       m_wready_i;
  logic       m_bvalid_i;

  int          errors;
  logic [63:0] cyc;
  logic        ifu_pend;
  logic        lsu_pend;
  logic        st_pend;
  time         ifu_done_t;
  time         lsu_done_t;
  logic [7:0]  shadow [0:4095];
  core_strb_t  masks [3] = '{8'h01, 8'h03, 8'h0f};

  core_bus_top dut (.*);

  axi_mem_model mem (
    .clk       (clk),
    .rst       (rst),
    .araddr_i  (m_araddr_o),
    .arvalid_i (m_arvalid_o),
    .arready_o (m_arready_i),
    .rvalid_o  (m_rvalid_i),
    .rdata_o   (m_rdata_i),
    .awaddr_i  (m_awaddr_o),
    .awvalid_i (m_awvalid_o),
    .awready_o (m_awready_i),
    .wdata_i   (m_wdata_o),
    .wstrb_i   (m_wstrb_o),
    .wvalid_i  (m_wvalid_o),
    .wready_o  (m_wready_i),
    .bvalid_o  (m_bvalid_i)
  );

  always #2 clk = ~clk;

  // cycles since rst fell
  // this is the expected mtime
  always @(posedge clk)
  begin
    if (rst)
      cyc <= '0;
    else
      cyc <= cyc + 64'd1;
  end

  // AR, AW and W must hold still while not accepted
  a_hold_ar: assert property (@(posedge clk) disable iff (rst)
    (m_arvalid_o && !m_arready_i) |=> (m_arvalid_o && $stable(m_araddr_o) && $stable(m_arsize_o)))
  else
  begin
    errors++;
    $display("AR channel changed while waiting for arready at %0t", $time);
  end

  a_hold_aw: assert property (@(posedge clk) disable iff (rst)
    (m_awvalid_o && !m_awready_i) |=> (m_awvalid_o && $stable(m_awaddr_o) && $stable(m_awsize_o)))
  else
  begin
    errors++;
    $display("AW channel changed while waiting for awready at %0t", $time);
  end

  a_hold_w: assert property (@(posedge clk) disable iff (rst)
    (m_wvalid_o && !m_wready_i) |=> (m_wvalid_o && $stable(m_wdata_o) && $stable(m_wstrb_o)))
  else
  begin
    errors++;
    $display("W channel changed while waiting for wready at %0t", $time);
  end

  // a pulse only reaches a side with something outstanding
  always @(negedge clk)
  begin
    if (!rst)
    begin
      assert (!ifu_rvalid_o || ifu_pend)
      else
      begin
        errors++;
        $display("ifu got a response with no fetch outstanding at %0t", $time);
      end
      assert (!lsu_rvalid_o || lsu_pend)
      else
      begin
        errors++;
        $display("lsu got a load response with no load outstanding at %0t", $time);
      end
      assert (!lsu_wready_o || st_pend)
      else
      begin
        errors++;
        $display("lsu got a store response with no store outstanding at %0t", $time);
      end
    end
  end

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act)
    else
    begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // half by bit 2, shifted down by offset, zero fill
  function automatic word_t expect_load(input addr_t a);
    word_t w;
    int    off;
    int    base;
    w    = '0;
    off  = int'(a[1:0]);
    base = int'({a[11:2], 2'b00});
    for (int i = 0; i < 4; i++)
      if (i + off < 4)
        w[8*i +: 8] = shadow[base + i + off];
    return w;
  endfunction

  function automatic axi_size_t size_for_mask(input core_strb_t m);
    if (m == 8'h01)
      return SIZE_BYTE;
    else if (m == 8'h03)
      return SIZE_HALF;
    return SIZE_WORD;
  endfunction

  task automatic ifu_fetch(input addr_t a);
    word_t exp;
    logic  seen;
    exp           = expect_load(a);
    seen          = 1'b0;
    ifu_araddr_i  = a;
    ifu_arvalid_i = 1'b1;
    ifu_pend      = 1'b1;
    do
    begin
      @(negedge clk);
      if (m_arvalid_o && m_araddr_o == a)
      begin
        seen = 1'b1;
        check_val("m_arsize_o", SIZE_WORD, m_arsize_o);
      end
    end while (!ifu_rvalid_o);
    assert (seen)
    else
    begin
      errors++;
      $display("ifu fetch of %h answered with no AR to that address at %0t", a, $time);
    end
    check_val("ifu_rdata_o", exp, ifu_rdata_o);
    ifu_done_t = $time;
    @(posedge clk);
    #1;
    ifu_arvalid_i = 1'b0;
    ifu_pend      = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic lsu_load(input addr_t a, input core_strb_t m);
    word_t exp;
    logic  seen;
    exp           = expect_load(a);
    seen          = 1'b0;
    lsu_araddr_i  = a;
    lsu_rstrb_i   = m;
    lsu_arvalid_i = 1'b1;
    lsu_pend      = 1'b1;
    do
    begin
      @(negedge clk);
      if (m_arvalid_o && m_araddr_o == a)
      begin
        seen = 1'b1;
        check_val("m_arsize_o", size_for_mask(m), m_arsize_o);
      end
    end while (!lsu_rvalid_o);
    assert (seen)
    else
    begin
      errors++;
      $display("lsu load of %h answered with no AR to that address at %0t", a, $time);
    end
    check_val("lsu_rdata_o", exp, lsu_rdata_o);
    lsu_done_t = $time;
    @(posedge clk);
    #1;
    lsu_arvalid_i = 1'b0;
    lsu_pend      = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic lsu_store(input addr_t a, input word_t d, input core_strb_t m);
    bus_strb_t exp_strb;
    int        off;
    int        half;
    logic      checked;
    exp_strb = '0;
    off      = int'(a[1:0]);
    half     = a[2] ? 4 : 0;
    checked  = 1'b0;
    for (int i = 0; i < 4; i++)
      if (m[i] && i + off < 4)
        exp_strb[half + off + i] = 1'b1;
    lsu_awaddr_i = a;
    lsu_wdata_i  = d;
    lsu_wstrb_i  = m;
    lsu_wvalid_i = 1'b1;
    st_pend      = 1'b1;
    do
    begin
      @(negedge clk);
      if (m_awvalid_o && !checked)
      begin
        checked = 1'b1;
        check_val("m_awaddr_o", a, m_awaddr_o);
        check_val("m_awsize_o", size_for_mask(m), m_awsize_o);
        check_val("m_wvalid_o", 1'b1, m_wvalid_o);
        check_val("m_wstrb_o", exp_strb, m_wstrb_o);
        for (int i = 0; i < 4; i++)
          if (m[i] && i + off < 4)
            check_val("m_wdata_o lane", d[8*i +: 8], m_wdata_o[8*(half + off + i) +: 8]);
      end
    end while (!lsu_wready_o);
    // shadow follows the same byte placement
    for (int i = 0; i < 4; i++)
      if (m[i] && i + off < 4)
        shadow[int'({a[11:2], 2'b00}) + off + i] = d[8*i +: 8];
    @(posedge clk);
    #1;
    lsu_wvalid_i = 1'b0;
    st_pend      = 1'b0;
    @(posedge clk);
    #1;
  endtask

  // answer lands exactly one cycle after the request
  task automatic clint_read(input logic hi);
    logic [63:0] t;
    word_t       exp;
    t             = cyc;
    exp           = hi ? t[63:32] : t[31:0];
    lsu_araddr_i  = hi ? CLINT_MTIME_HI : CLINT_MTIME_LO;
    lsu_rstrb_i   = 8'h0f;
    lsu_arvalid_i = 1'b1;
    lsu_pend      = 1'b1;
    @(negedge clk);
    check_val("lsu_rvalid_o", 1'b0, lsu_rvalid_o);
    check_val("m_arvalid_o", 1'b0, m_arvalid_o);
    @(negedge clk);
    check_val("lsu_rvalid_o", 1'b1, lsu_rvalid_o);
    check_val("m_arvalid_o", 1'b0, m_arvalid_o);
    check_val("lsu_rdata_o", exp, lsu_rdata_o);
    @(posedge clk);
    #1;
    lsu_arvalid_i = 1'b0;
    lsu_pend      = 1'b0;
    @(posedge clk);
    #1;
  endtask

  initial
  begin
    word_t store_data;
    void'($urandom(32'h5f1b));
    errors        = 0;
    clk           = 1'b0;
    rst           = 1'b1;
    ifu_arvalid_i = 1'b0;
    ifu_araddr_i  = '0;
    lsu_arvalid_i = 1'b0;
    lsu_araddr_i  = '0;
    lsu_rstrb_i   = '0;
    lsu_wvalid_i  = 1'b0;
    lsu_awaddr_i  = '0;
    lsu_wdata_i   = '0;
    lsu_wstrb_i   = '0;
    ifu_pend      = 1'b0;
    lsu_pend      = 1'b0;
    st_pend       = 1'b0;
    // same fill pattern the memory starts from
    for (int i = 0; i < 4096; i++)
      shadow[i] = 8'(i) ^ {4'(i), 4'(i >> 8)} ^ 8'h5a;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    // bus stays quiet with no requests
    repeat (4)
    begin
      @(negedge clk);
      check_val("m_arvalid_o", 1'b0, m_arvalid_o);
      check_val("m_awvalid_o", 1'b0, m_awvalid_o);
      check_val("m_wvalid_o", 1'b0, m_wvalid_o);
      check_val("ifu_rvalid_o", 1'b0, ifu_rvalid_o);
      check_val("lsu_rvalid_o", 1'b0, lsu_rvalid_o);
      check_val("lsu_wready_o", 1'b0, lsu_wready_o);
    end
    @(posedge clk);
    #1;
    clint_read(1'b0);
    clint_read(1'b1);
    ifu_fetch(32'h0000_0100);
    ifu_fetch(32'h0000_0104);
    ifu_fetch(32'h0000_0208);
    ifu_fetch(32'h0000_020c);
    for (int s = 0; s < 3; s++)
      for (int off = 0; off < 8; off++)
        lsu_load(32'h0000_0400 + off, masks[s]);
    // odd mask goes out as a word
    lsu_load(32'h0000_0410, 8'h05);
    // both raised together so lsu goes first
    fork
      ifu_fetch(32'h0000_0500);
      lsu_load(32'h0000_0603, 8'h01);
    join
    assert (lsu_done_t < ifu_done_t)
    else
    begin
      errors++;
      $display("ifu was served before lsu when both asked in the same cycle");
    end
    for (int s = 0; s < 3; s++)
      for (int off = 0; off < 8; off++)
      begin
        store_data = $urandom;
        lsu_store(32'h0000_0300 + off, store_data, masks[s]);
        lsu_load(32'h0000_0300 + off, masks[s]);
      end
    // store issued under a pending fetch
    fork
      ifu_fetch(32'h0000_0700);
      begin
        @(posedge clk);
        #1;
        lsu_store(32'h0000_0800, 32'hcafe_f00d, 8'h0f);
      end
    join
    lsu_load(32'h0000_0800, 8'h0f);
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  initial
  begin
    repeat (RST_CYCLES + N_OPS * 20) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", RST_CYCLES + N_OPS * 20);
    $display("errors: %0d", errors);
    $display("Done: errors found");
    $finish;
  end

endmodule
